//--- multiplier_settings.svh
`ifndef MULTIPLIER_SETTINGS_SVH
`define MULTIPLIER_SETTINGS_SVH

// Width of each input operand.
`define OperandWidth 32

// Full product width, twice the operand width.
`define ProductWidth 64

// One add-and-shift iteration per multiplier bit.
`define StepCount 32

// Iteration counter width, enough to count StepCount steps.
`define CountWidth 5

`endif

//--- mulDataPkg.sv
`include "multiplier_settings.svh"

package mulDataPkg;

	// One operand word.
	typedef logic [`OperandWidth-1:0] dataWord;

	// Raw operands as they arrive at the top level.
	typedef struct packed
	{
		dataWord operandA;
		dataWord operandB;
	} operandPair;

	// Operands after sign handling.
	// Both magnitudes are unsigned; negateResult tells the output side
	// to negate the finished product.
	typedef struct packed
	{
		dataWord magnitudeA;
		dataWord magnitudeB;
		logic negateResult;
	} conditionedOperands;

	// Working register seen as accumulator over multiplier.
	// The accumulator collects partial sums, the multiplier is consumed
	// one bit per step from its lsb.
	typedef struct packed
	{
		dataWord accumulator;
		dataWord multiplier;
	} splitView;

	// Same 64 bits, read either as the finished product or as two halves.
	typedef union packed
	{
		logic [`ProductWidth-1:0] full;
		splitView split;
	} workingRegister;

endpackage

//--- mulControlPkg.sv
package mulControlPkg;

	// Controller states.
	// Idle waits for validData, Calc runs the iterations,
	// Finish hands the result over, Done holds it until ack.
	typedef enum logic [1:0]
	{
		Idle   = 2'd0,
		Calc   = 2'd1,
		Finish = 2'd2,
		Done   = 2'd3
	} controllerState;

	// Control strobes from the controller.
	// At most one of them is high in any cycle.
	typedef struct packed
	{
		// Take new operands into the datapath.
		logic load;
		// Run one add-and-shift iteration.
		logic step;
		// Copy the signed product to the output side.
		logic capture;
		// Clear the done flag, product stays.
		logic releaseResult;
	} controlStrobes;

endpackage

//--- operandConditioner.sv
`timescale 1ns/10ps
`include "multiplier_settings.svh"

module operandConditioner
	import mulDataPkg::*;
(
	input operandPair operands,
	input logic signedMode,
	output conditionedOperands conditioned
);

	// Sign bits of the raw operands.
	logic signA;
	logic signB;

	// Two's-complement negations of both operands.
	dataWord negatedA;
	dataWord negatedB;

	assign signA = operands.operandA[`OperandWidth-1];
	assign signB = operands.operandB[`OperandWidth-1];

	assign negatedA = -operands.operandA;
	assign negatedB = -operands.operandB;

	always_comb
	begin
		// Unsigned mode passes the words straight through.
		conditioned.magnitudeA = operands.operandA;
		conditioned.magnitudeB = operands.operandB;
		conditioned.negateResult = 1'b0;
		if (signedMode)
		begin
			// Negative operands become their magnitude.
			// The most negative value maps to 2**31, still exact unsigned.
			if (signA)
			begin
				conditioned.magnitudeA = negatedA;
			end
			if (signB)
			begin
				conditioned.magnitudeB = negatedB;
			end
			// Result is negative when exactly one operand was.
			conditioned.negateResult = signA ^ signB;
		end
	end

endmodule

//--- multiplyController.sv
`timescale 1ns/10ps
`include "multiplier_settings.svh"

module multiplyController
	import mulControlPkg::*;
(
	input logic Clock,
	input logic Reset,
	input logic validData,
	input logic ack,
	input logic multiplierLsb,
	output controlStrobes strobes,
	output logic busy
);

	// Count value during the last iteration.
	localparam logic [`CountWidth-1:0] LastStep = `CountWidth'(`StepCount - 1);

	// Current and next state.
	controllerState state;
	controllerState nextState;

	// Iteration counter.
	logic [`CountWidth-1:0] stepCount;

	// State register.
	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			state <= Idle;
		end
		else
		begin
			state <= nextState;
		end
	end

	// Counter restarts with every new operand pair.
	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			stepCount <= '0;
		end
		else if (strobes.load)
		begin
			stepCount <= '0;
		end
		else if (strobes.step)
		begin
			stepCount <= stepCount + 1'b1;
		end
	end

	// Next state logic.
	always_comb
	begin
		nextState = state;
		case (state)
			Idle:
			begin
				// validData is only looked at here.
				if (validData)
				begin
					nextState = Calc;
				end
			end
			Calc:
			begin
				// Leave after the thirty-second step.
				if (stepCount == LastStep)
				begin
					nextState = Finish;
				end
			end
			Finish:
			begin
				nextState = Done;
			end
			Done:
			begin
				// Result is held as long as ack stays low.
				if (ack)
				begin
					nextState = Idle;
				end
			end
			default:
			begin
				nextState = Idle;
			end
		endcase
	end

	// Strobes decode from the state; load and release also need their level input.
	always_comb
	begin
		strobes = '0;
		strobes.load = (state == Idle) && validData;
		strobes.step = (state == Calc);
		strobes.capture = (state == Finish);
		strobes.releaseResult = (state == Done) && ack;
	end

	// Busy while the product is being formed.
	assign busy = (state == Calc) || (state == Finish);

	// A load is followed by exactly 32 Calc cycles and then Finish.
	assert property (@(posedge Clock) disable iff (Reset)
		strobes.load |=> (state == Calc) [*`StepCount] ##1 (state == Finish))
		else $error("Calc did not last %0d cycles", `StepCount);

	// The datapath lsb must be a known value while iterating.
	assert property (@(posedge Clock) disable iff (Reset)
		(state == Calc) |-> !$isunknown(multiplierLsb))
		else $error("multiplierLsb unknown during Calc");

endmodule

//--- shiftAddDatapath.sv
`timescale 1ns/10ps
`include "multiplier_settings.svh"

module shiftAddDatapath
	import mulDataPkg::*;
	import mulControlPkg::*;
(
	input logic Clock,
	input logic Reset,
	input controlStrobes strobes,
	input conditionedOperands conditioned,
	output logic multiplierLsb,
	output workingRegister working,
	output logic negateResult
);

	// Multiplicand kept for the whole operation.
	dataWord magnitudeA;

	// Accumulator plus addend, with the carry bit on top.
	logic [`OperandWidth:0] partialSum;

	// Register contents after one add-and-shift step.
	workingRegister nextWorking;

	// The current multiplier bit decides whether to add.
	assign multiplierLsb = working.split.multiplier[0];

	always_comb
	begin
		partialSum = {1'b0, working.split.accumulator};
		if (multiplierLsb)
		begin
			partialSum = partialSum + {1'b0, magnitudeA};
		end
		// Shift right by one, the carry moves into the accumulator msb.
		// The sum lsb drops into the freed top bit of the multiplier half.
		nextWorking.full = {partialSum, working.split.multiplier[`OperandWidth-1:1]};
	end

	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			working <= '0;
			magnitudeA <= '0;
			negateResult <= 1'b0;
		end
		else if (strobes.load)
		begin
			// Fresh start: empty accumulator, multiplier in the low half.
			working.split.accumulator <= '0;
			working.split.multiplier <= conditioned.magnitudeB;
			magnitudeA <= conditioned.magnitudeA;
			negateResult <= conditioned.negateResult;
		end
		else if (strobes.step)
		begin
			working <= nextWorking;
		end
	end

endmodule

//--- resultFormatter.sv
`timescale 1ns/10ps
`include "multiplier_settings.svh"

module resultFormatter
	import mulDataPkg::*;
	import mulControlPkg::*;
(
	input logic Clock,
	input logic Reset,
	input controlStrobes strobes,
	input workingRegister working,
	input logic negateResult,
	output logic [`ProductWidth-1:0] product,
	output logic doneFlag
);

	// Product with the sign restored.
	logic [`ProductWidth-1:0] signedProduct;

	assign signedProduct = negateResult ? -working.full : working.full;

	always_ff @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			product <= '0;
			doneFlag <= 1'b0;
		end
		else if (strobes.capture)
		begin
			product <= signedProduct;
			doneFlag <= 1'b1;
		end
		else if (strobes.releaseResult)
		begin
			// Only the flag drops; the last product stays readable.
			doneFlag <= 1'b0;
		end
	end

	// Product is frozen while the result is on offer.
	assert property (@(posedge Clock) disable iff (Reset)
		doneFlag |=> $stable(product))
		else $error("product changed while doneFlag high: %h", product);

endmodule

//--- shiftAddMultiplier.sv
`timescale 1ns/10ps
`include "multiplier_settings.svh"

module shiftAddMultiplier
	import mulDataPkg::*;
	import mulControlPkg::*;
(
	input logic Clock,
	input logic Reset,
	input logic validData,
	input logic signedMode,
	input operandPair operands,
	input logic ack,
	output logic busy,
	output logic doneFlag,
	output logic [`ProductWidth-1:0] product
);

	// Magnitudes and sign request from the input side.
	conditionedOperands conditioned;

	// Controller strobes to datapath and output side.
	controlStrobes strobes;

	// Datapath state seen by the controller and the output side.
	logic multiplierLsb;
	workingRegister working;
	logic negateResult;

	// Input side.
	operandConditioner operandConditioner_inst
	(
		.operands(operands),
		.signedMode(signedMode),
		.conditioned(conditioned)
	);

	// Sequencing.
	multiplyController multiplyController_inst
	(
		.Clock(Clock),
		.Reset(Reset),
		.validData(validData),
		.ack(ack),
		.multiplierLsb(multiplierLsb),
		.strobes(strobes),
		.busy(busy)
	);

	// Add-and-shift engine.
	shiftAddDatapath shiftAddDatapath_inst
	(
		.Clock(Clock),
		.Reset(Reset),
		.strobes(strobes),
		.conditioned(conditioned),
		.multiplierLsb(multiplierLsb),
		.working(working),
		.negateResult(negateResult)
	);

	// Output side.
	resultFormatter resultFormatter_inst
	(
		.Clock(Clock),
		.Reset(Reset),
		.strobes(strobes),
		.working(working),
		.negateResult(negateResult),
		.product(product),
		.doneFlag(doneFlag)
	);

endmodule

//--- shiftAddMultiplierTb.sv
`timescale 1ns/10ps
`include "multiplier_settings.svh"

module shiftAddMultiplierTb
	import mulDataPkg::*;
();

	// Corner values and random draws, both modes.
	localparam int CornerCount = 4;
	localparam int RandomCount = 20;
	localparam int TestCount = 2 * (CornerCount * CornerCount + RandomCount);

	// Each test takes at most about 40 cycles.
	localparam int CycleLimit = TestCount * 40 + 100;

	// Edges from the accepting edge to the rise of doneFlag.
	localparam int DoneLatency = 33;

	// DUT ports.
	logic Clock;
	logic Reset;
	logic validData;
	logic signedMode;
	logic ack;
	operandPair operands;
	logic busy;
	logic doneFlag;
	logic [`ProductWidth-1:0] product;

	// Xorshift state.
	logic [31:0] rngState = 32'd84904;

	// Bookkeeping.
	int errorCount = 0;
	int testCount = 0;
	int edgeCount = 0;
	logic [31:0] corners [CornerCount];

	// Reference model state.
	logic inFlight;
	int acceptEdge;
	int elapsed;
	logic [`ProductWidth-1:0] expectedProduct;
	logic expectedBusy;
	logic expectedDone;

	shiftAddMultiplier shiftAddMultiplier_inst
	(
		.Clock(Clock),
		.Reset(Reset),
		.validData(validData),
		.signedMode(signedMode),
		.operands(operands),
		.ack(ack),
		.busy(busy),
		.doneFlag(doneFlag),
		.product(product)
	);

	initial
	begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;
	end

	// 32-bit xorshift generator.
	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// Product by the rule: extend each operand by its sign in signed mode.
	function automatic logic [63:0] referenceProduct(input logic [31:0] a,
		input logic [31:0] b, input logic isSigned);
		logic [63:0] wideA;
		logic [63:0] wideB;
		wideA = {32'b0, a};
		wideB = {32'b0, b};
		if (isSigned)
		begin
			wideA = {{32{a[31]}}, a};
			wideB = {{32{b[31]}}, b};
		end
		return wideA * wideB;
	endfunction

	// Number of the last edge passed, also the run limit.
	always @(posedge Clock)
	begin
		edgeCount <= edgeCount + 1;
		if (edgeCount >= CycleLimit)
		begin
			$display("Timeout: DUT did not finish within %0d cycles", CycleLimit);
			$display("Checks failed");
			$finish;
		end
	end

	// Model of the handshake.
	// It accepts in its own idle phase and leaves on ack once done.
	always @(posedge Clock or posedge Reset)
	begin
		if (Reset)
		begin
			inFlight <= 1'b0;
			acceptEdge <= 0;
			expectedProduct <= '0;
		end
		else if (!inFlight && validData)
		begin
			inFlight <= 1'b1;
			acceptEdge <= edgeCount + 1;
			expectedProduct <= referenceProduct(operands.operandA, operands.operandB,
				signedMode);
		end
		else if (inFlight && elapsed >= DoneLatency && ack)
		begin
			inFlight <= 1'b0;
		end
	end

	assign elapsed = edgeCount - acceptEdge;
	assign expectedBusy = inFlight && (elapsed < DoneLatency);
	assign expectedDone = inFlight && (elapsed >= DoneLatency);

	// Outputs are clear while reset is held.
	assert property (@(posedge Clock) (Reset && edgeCount > 0)
		|-> (!busy && !doneFlag && product == '0))
		else
		begin
			errorCount++;
			$display("Outputs not cleared during reset");
		end

	assert property (@(posedge Clock) disable iff (Reset) busy == expectedBusy)
		else
		begin
			errorCount++;
			$display("FAIL busy: got %h expected %h", $sampled(busy), $sampled(expectedBusy));
		end

	assert property (@(posedge Clock) disable iff (Reset) doneFlag == expectedDone)
		else
		begin
			errorCount++;
			$display("FAIL doneFlag: got %h expected %h", $sampled(doneFlag),
				$sampled(expectedDone));
		end

	// doneFlag rises a fixed number of edges after acceptance.
	assert property (@(posedge Clock) disable iff (Reset)
		$rose(doneFlag) |-> (inFlight && elapsed == DoneLatency))
		else
		begin
			errorCount++;
			$display("doneFlag rose %0d edges after acceptance", $sampled(elapsed));
		end

	assert property (@(posedge Clock) disable iff (Reset)
		expectedDone |-> (product == expectedProduct))
		else
		begin
			errorCount++;
			$display("FAIL product: got %h expected %h", $sampled(product),
				$sampled(expectedProduct));
		end

	// Product stays put through the ack edge.
	assert property (@(posedge Clock) disable iff (Reset) expectedDone |=> $stable(product))
		else
		begin
			errorCount++;
			$display("Product changed while the result was held");
		end

	// Inputs that the DUT must ignore.
	task automatic driveNoise();
		logic [31:0] noise;
		noise = nextRandom();
		validData <= noise[0];
		signedMode <= noise[1];
		operands.operandA <= nextRandom();
		operands.operandB <= noise;
	endtask

	// One multiplication, from request to ack.
	task automatic runMultiply(input logic [31:0] a, input logic [31:0] b,
		input logic isSigned);
		logic [31:0] holdRandom;
		int holdCycles;
		holdRandom = nextRandom();
		holdCycles = int'(holdRandom[1:0]);
		@(posedge Clock);
		operands.operandA <= a;
		operands.operandB <= b;
		signedMode <= isSigned;
		validData <= 1'b1;
		@(posedge Clock);
		// Accepted here; keep the inputs moving while busy.
		do
		begin
			driveNoise();
			@(posedge Clock);
		end
		while (!doneFlag);
		// Result must stay while ack is low.
		repeat (holdCycles)
		begin
			driveNoise();
			@(posedge Clock);
		end
		driveNoise();
		ack <= 1'b1;
		@(posedge Clock);
		ack <= 1'b0;
		validData <= 1'b0;
		testCount++;
	endtask

	initial
	begin
		logic [31:0] randomA;
		logic [31:0] randomB;
		Reset = 1'b1;
		validData = 1'b0;
		signedMode = 1'b0;
		ack = 1'b0;
		operands = '0;
		corners[0] = 32'h0000_0000;
		corners[1] = 32'h0000_0001;
		corners[2] = 32'hFFFF_FFFF;
		corners[3] = 32'h8000_0000;
		repeat (4) @(posedge Clock);
		Reset <= 1'b0;
		// Every corner pair, unsigned first.
		for (int mode = 0; mode < 2; mode++)
		begin
			for (int i = 0; i < CornerCount; i++)
			begin
				for (int j = 0; j < CornerCount; j++)
				begin
					runMultiply(corners[i], corners[j], mode[0]);
				end
			end
		end
		// Random operands, signed runs cycle through all sign pairs.
		for (int mode = 0; mode < 2; mode++)
		begin
			for (int k = 0; k < RandomCount; k++)
			begin
				randomA = nextRandom();
				randomB = nextRandom();
				if (mode == 1)
				begin
					randomA[31] = k[0];
					randomB[31] = k[1];
				end
				runMultiply(randomA, randomB, mode[0]);
			end
		end
		repeat (2) @(posedge Clock);
		$display("Tests run: %0d, errors: %0d", testCount, errorCount);
		if (errorCount == 0)
		begin
			$display("All checks passed");
		end
		else
		begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+.
mulDataPkg.sv
mulControlPkg.sv
operandConditioner.sv
multiplyController.sv
shiftAddDatapath.sv
resultFormatter.sv
shiftAddMultiplier.sv
shiftAddMultiplierTb.sv

//--- Makefile
# Verilator build and run for the shift-and-add multiplier.

VERILATOR ?= verilator
TOP ?= shiftAddMultiplierTb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "All checks passed" $(LOG); then \
		echo "Simulation ended early, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
